// ==== rtl/rvCorePkg.sv ====
// RV32I core shared definitions
package rvCorePkg;

    // Data path and address width
    localparam int XLEN = 32;

    // Register index width
    localparam int REG_ADDR_W = 5;

    // Wishbone byte select width, word accesses only
    localparam int WB_SEL_W = 4;

    // Supported major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // func3 codes in use
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // LW and SW width code
    localparam logic [2:0] F3_WORD    = 3'b010;

    // func7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ALU operations
    typedef enum logic [2:0]
    {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        // Operand B straight through, for LUI
        ALU_PASSB = 3'd6
    } aluOpT;

endpackage

// ==== rtl/instrFetch.sv ====
// Instruction fetch unit
`timescale 1ns/1ps

module instrFetch
    import rvCorePkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            fetchStart,
    input  logic [XLEN-1:0] nextPc,
    input  logic            pcAdvance,
    output logic            iCyc,
    output logic            iStb,
    output logic [XLEN-1:0] iAdr,
    input  logic [XLEN-1:0] iDatRd,
    input  logic            iAck,
    output logic            fetchDone,
    output logic [XLEN-1:0] instrWord,
    output logic [XLEN-1:0] pc
);

    // Program counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= '0;
        else if (pcAdvance)
            pc <= nextPc;
    end

    // Bus cycle control, one read per request
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            iCyc <= 1'b0;
        else if (fetchStart)
            iCyc <= 1'b1;
        else if (iCyc && iAck)
            // Released in the cycle after ack
            iCyc <= 1'b0;
    end

    // Captured instruction word
    always_ff @(posedge clk)
    begin
        if (iCyc && iAck)
            instrWord <= iDatRd;
    end

    // Strobe follows cycle, single transfer
    assign iStb = iCyc;
    // PC is the fetch address
    assign iAdr = pc;
    assign fetchDone = iCyc && iAck;

    // Request must hold until the slave answers
    holdUntilAck: assert property (@(posedge clk) disable iff (rst)
        (iStb && !iAck) |=> (iStb && $stable(iAdr)));

endmodule

// ==== rtl/decode.sv ====
// Instruction decoder
`timescale 1ns/1ps

module decode
    import rvCorePkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrLoad,
    input  logic [XLEN-1:0]       nextInstruction,
    output logic [XLEN-1:0]       imm,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output aluOpT                 aluOp,
    output logic                  aluSrc,
    output logic                  regWrite,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memToReg
);

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [6:0]      func7;

    // Instruction register, zero decodes as a no-operation
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            instr <= '0;
        else if (instrLoad)
            instr <= nextInstruction;
    end

    // Field split
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign func3  = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign func7  = instr[31:25];

    // Immediate and control decode
    always_comb
    begin
        // No-operation unless matched below
        imm      = {{20{instr[31]}}, instr[31:20]};
        aluOp    = ALU_ADD;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;

        case (opcode)
            OPC_LUI:
            begin
                // U-type, low twelve bits zero
                imm      = {instr[31:12], 12'b0};
                aluOp    = ALU_PASSB;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OPC_OP_IMM:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (func3)
                    F3_ADD_SUB: aluOp = ALU_ADD;
                    F3_SLT:     aluOp = ALU_SLT;
                    F3_XOR:     aluOp = ALU_XOR;
                    F3_OR:      aluOp = ALU_OR;
                    F3_AND:     aluOp = ALU_AND;
                    // Shifts and SLTIU not supported
                    default:    regWrite = 1'b0;
                endcase
            end
            OPC_OP:
            begin
                regWrite = 1'b1;
                if (func3 == F3_ADD_SUB && func7 == F7_SUB)
                    aluOp = ALU_SUB;
                else if (func7 != 7'b0000000)
                    regWrite = 1'b0;
                else
                begin
                    case (func3)
                        F3_ADD_SUB: aluOp = ALU_ADD;
                        F3_SLT:     aluOp = ALU_SLT;
                        F3_XOR:     aluOp = ALU_XOR;
                        F3_OR:      aluOp = ALU_OR;
                        F3_AND:     aluOp = ALU_AND;
                        default:    regWrite = 1'b0;
                    endcase
                end
            end
            OPC_LOAD:
            begin
                // LW only, address is rs1 plus I immediate
                if (func3 == F3_WORD)
                begin
                    aluSrc   = 1'b1;
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                end
            end
            OPC_STORE:
            begin
                // S-type immediate split across two fields
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (func3 == F3_WORD)
                begin
                    aluSrc   = 1'b1;
                    memWrite = 1'b1;
                end
            end
            default:
            begin
                // Unsupported opcode retires as no-operation
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
// Integer register file
`timescale 1ns/1ps

module regFile
    import rvCorePkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rs1Data,
    output logic [XLEN-1:0]       rs2Data,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Single write port, x0 never written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
            regs[rd] <= wdata;
    end

    // Combinational read ports
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

// ==== rtl/alu.sv ====
// Integer ALU
`timescale 1ns/1ps

module alu
    import rvCorePkg::*;
(
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    input  aluOpT           aluOp,
    output logic [XLEN-1:0] result
);

    logic lessThan;

    // Signed compare for SLT and SLTI
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb
    begin
        case (aluOp)
            ALU_ADD:
                result = opA + opB;
            ALU_SUB:
                result = opA - opB;
            ALU_AND:
                result = opA & opB;
            ALU_OR:
                result = opA | opB;
            ALU_XOR:
                result = opA ^ opB;
            ALU_SLT:
                // Flag in bit zero
                result = {{(XLEN-1){1'b0}}, lessThan};
            ALU_PASSB:
                result = opB;
            default:
                result = opA + opB;
        endcase
    end

endmodule

// ==== rtl/memAccess.sv ====
// Data memory access unit
`timescale 1ns/1ps

module memAccess
    import rvCorePkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                execLatch,
    input  logic                memStart,
    input  logic                memWrite,
    input  logic                memToReg,
    input  logic [XLEN-1:0]     addr,
    input  logic [XLEN-1:0]     storeData,
    output logic                dCyc,
    output logic                dStb,
    output logic                dWe,
    output logic [XLEN-1:0]     dAdr,
    output logic [XLEN-1:0]     dDatWr,
    output logic [WB_SEL_W-1:0] dSel,
    input  logic [XLEN-1:0]     dDatRd,
    input  logic                dAck,
    output logic                memDone,
    output logic [XLEN-1:0]     loadData
);

    logic [XLEN-1:0] resultReg;
    logic [XLEN-1:0] storeReg;
    logic [XLEN-1:0] loadReg;

    // Execute register, ALU result and store data
    always_ff @(posedge clk)
    begin
        if (execLatch)
        begin
            resultReg <= addr;
            storeReg  <= storeData;
        end
    end

    // One word transfer per request
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dCyc <= 1'b0;
            dWe  <= 1'b0;
        end
        else if (memStart)
        begin
            dCyc <= 1'b1;
            dWe  <= memWrite;
        end
        else if (dCyc && dAck)
        begin
            dCyc <= 1'b0;
            dWe  <= 1'b0;
        end
    end

    // Read data taken at ack
    always_ff @(posedge clk)
    begin
        if (dCyc && dAck && !dWe)
            loadReg <= dDatRd;
    end

    assign dStb    = dCyc;
    assign dAdr    = resultReg;
    assign dDatWr  = storeReg;
    // Word accesses only
    assign dSel    = '1;
    assign memDone = dCyc && dAck;

    // Writeback select, memory or ALU
    assign loadData = memToReg ? loadReg : resultReg;

    // Word alignment for the whole bus cycle
    wordAligned: assert property (@(posedge clk) disable iff (rst)
        dCyc |-> (dAdr[1:0] == 2'b00));

endmodule

// ==== rtl/coreSequencer.sv ====
// Instruction phase sequencer
`timescale 1ns/1ps

module coreSequencer (
    input  logic clk,
    input  logic rst,
    input  logic fetchDone,
    input  logic memDone,
    input  logic memRead,
    input  logic memWrite,
    output logic fetchStart,
    output logic instrLoad,
    output logic execLatch,
    output logic memStart,
    output logic wbEn,
    output logic pcAdvance
);

    typedef enum logic [2:0]
    {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_WRITEBACK
    } stateT;

    stateT state;
    stateT stateNext;
    // High in the first cycle of each phase
    logic  phaseEntry;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= S_FETCH;
            // Kicks off the first fetch out of reset
            phaseEntry <= 1'b1;
        end
        else
        begin
            state      <= stateNext;
            phaseEntry <= (stateNext != state);
        end
    end

    // Next phase
    always_comb
    begin
        stateNext = state;
        case (state)
            S_FETCH:
                if (fetchDone)
                    stateNext = S_DECODE;
            S_DECODE:
                stateNext = S_EXECUTE;
            S_EXECUTE:
                // Memory phase only for LW and SW
                stateNext = (memRead || memWrite) ? S_MEM : S_WRITEBACK;
            S_MEM:
                if (memDone)
                    stateNext = S_WRITEBACK;
            S_WRITEBACK:
                stateNext = S_FETCH;
            default:
                stateNext = S_FETCH;
        endcase
    end

    // Phase strobes
    assign fetchStart = (state == S_FETCH) && phaseEntry;
    assign instrLoad  = (state == S_DECODE);
    assign execLatch  = (state == S_EXECUTE);
    assign memStart   = (state == S_MEM) && phaseEntry;
    assign wbEn       = (state == S_WRITEBACK);
    // PC steps as the instruction retires
    assign pcAdvance  = wbEn;

    // Only one bus request at a time
    oneRequest: assert property (@(posedge clk) disable iff (rst)
        !(fetchStart && memStart));

endmodule

// ==== rtl/rvCore.sv ====
// Multicycle RV32I core
`timescale 1ns/1ps

module rvCore
    import rvCorePkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Instruction bus, read only
    output logic                  iCyc,
    output logic                  iStb,
    output logic [XLEN-1:0]       iAdr,
    input  logic [XLEN-1:0]       iDatRd,
    input  logic                  iAck,
    // Data bus
    output logic                  dCyc,
    output logic                  dStb,
    output logic                  dWe,
    output logic [XLEN-1:0]       dAdr,
    output logic [XLEN-1:0]       dDatWr,
    output logic [WB_SEL_W-1:0]   dSel,
    input  logic [XLEN-1:0]       dDatRd,
    input  logic                  dAck,
    // Retirement trace
    output logic                  retireValid,
    output logic [XLEN-1:0]       retirePc,
    output logic                  retireRegWrite,
    output logic [REG_ADDR_W-1:0] retireRd,
    output logic [XLEN-1:0]       retireData
);

    // Sequencer strobes
    logic fetchStart;
    logic fetchDone;
    logic instrLoad;
    logic execLatch;
    logic memStart;
    logic memDone;
    logic wbEn;
    logic pcAdvance;

    // Fetch path
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] instrWord;

    // Decoded controls
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    aluOpT                 aluOp;
    logic                  aluSrc;
    logic                  regWrite;
    logic                  memRead;
    logic                  memWrite;
    logic                  memToReg;

    // Operands and results
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluOpB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] wbData;
    logic            regWe;

    // Straight-line PC, no control transfer
    assign nextPc = pc + XLEN'(4);
    // Immediate or rs2 as second operand
    assign aluOpB = aluSrc ? imm : rs2Data;
    assign regWe  = wbEn && regWrite;

    instrFetch uFetch (
        .clk(clk), .rst(rst), .fetchStart(fetchStart), .nextPc(nextPc),
        .pcAdvance(pcAdvance), .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr),
        .iDatRd(iDatRd), .iAck(iAck), .fetchDone(fetchDone),
        .instrWord(instrWord), .pc(pc)
    );

    decode uDecode (
        .clk(clk), .rst(rst), .instrLoad(instrLoad), .nextInstruction(instrWord),
        .imm(imm), .rd(rd), .rs1(rs1), .rs2(rs2), .aluOp(aluOp), .aluSrc(aluSrc),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memToReg(memToReg)
    );

    regFile uRegs (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data),
        .rs2Data(rs2Data), .we(regWe), .rd(rd), .wdata(wbData)
    );

    alu uAlu (
        .opA(rs1Data), .opB(aluOpB), .aluOp(aluOp), .result(aluResult)
    );

    memAccess uMem (
        .clk(clk), .rst(rst), .execLatch(execLatch), .memStart(memStart),
        .memWrite(memWrite), .memToReg(memToReg), .addr(aluResult),
        .storeData(rs2Data), .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr),
        .dDatWr(dDatWr), .dSel(dSel), .dDatRd(dDatRd), .dAck(dAck),
        .memDone(memDone), .loadData(wbData)
    );

    coreSequencer uSeq (
        .clk(clk), .rst(rst), .fetchDone(fetchDone), .memDone(memDone),
        .memRead(memRead), .memWrite(memWrite), .fetchStart(fetchStart),
        .instrLoad(instrLoad), .execLatch(execLatch), .memStart(memStart),
        .wbEn(wbEn), .pcAdvance(pcAdvance)
    );

    // Trace of the instruction in writeback
    assign retireValid    = wbEn;
    assign retirePc       = pc;
    assign retireRegWrite = regWrite;
    assign retireRd       = rd;
    assign retireData     = wbData;

endmodule

// ==== sim/tbMemory.sv ====
// Wishbone slave memory model
`timescale 1ns/1ps

module tbMemory #(
    parameter int          ADDR_W = 8,
    parameter logic [31:0] SEED   = 32'h976f7412
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] init [2**ADDR_W],
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] datWr,
    input  logic [3:0]  sel,
    output logic [31:0] datRd = '0,
    output logic        ack = 1'b0
);

    logic [31:0]       mem [2**ADDR_W];
    logic [31:0]       lfsr;
    logic [31:0]       stepState;
    logic              busy;
    logic [1:0]        waitLeft;
    logic [1:0]        waitNow;
    logic [ADDR_W-1:0] idx;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    assign idx = adr[ADDR_W+1:2];

    // Responses change on the falling edge
    always @(negedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack      <= 1'b0;
            busy     <= 1'b0;
            waitLeft <= 2'd0;
            lfsr     <= SEED;
            datRd    <= '0;
            // Contents come from the testbench image
            for (int i = 0; i < 2**ADDR_W; i++)
                mem[i] <= init[i];
        end
        else if (ack)
            // Single cycle ack, master releases next
            ack <= 1'b0;
        else if (cyc && stb)
        begin
            if (!busy)
            begin
                // Zero to three wait states per request
                stepState  = lfsrNext(lfsr);
                waitNow[1] = stepState[0];
                stepState  = lfsrNext(stepState);
                waitNow[0] = stepState[0];
                lfsr      <= stepState;
            end
            else
                waitNow = waitLeft;

            if (waitNow == 2'd0)
            begin
                ack  <= 1'b1;
                busy <= 1'b0;
                if (we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (sel[b])
                            mem[idx][8*b +: 8] <= datWr[8*b +: 8];
                end
                else
                    datRd <= mem[idx];
            end
            else
            begin
                busy     <= 1'b1;
                waitLeft <= waitNow - 2'd1;
            end
        end
    end

endmodule

// ==== sim/rvCoreTb.sv ====
// RV32I core testbench
`timescale 1ns/1ps

module rvCoreTb
    import rvCorePkg::*;
;

    localparam int          N_INSTR = 200;
    localparam int          IMEM_AW = 8;
    localparam int          DMEM_AW = 6;
    localparam int          TIMEOUT = 100;
    localparam logic [31:0] SEED    = 32'h976f7412;

    logic        clk;
    logic        rst;
    logic        iCyc, iStb, iAck;
    logic [31:0] iAdr, iDatRd;
    logic        dCyc, dStb, dWe, dAck;
    logic [31:0] dAdr, dDatWr, dDatRd;
    logic [3:0]  dSel;
    logic        retireValid, retireRegWrite;
    logic [31:0] retirePc, retireData;
    logic [4:0]  retireRd;

    logic [31:0] progImage [2**IMEM_AW];
    logic [31:0] dataImage [2**DMEM_AW];
    // Reference model state
    logic [31:0] mregs [32];
    logic [31:0] mmem [2**DMEM_AW];
    logic        expWr [N_INSTR];
    logic [4:0]  expRd [N_INSTR];
    logic [31:0] expData [N_INSTR];
    // Expected data bus writes, address over data
    logic [63:0] storeQ [$];
    logic [63:0] expStore;
    logic        storeSeen = 1'b0;
    logic [31:0] lfsrState;
    logic [31:0] genBase;
    // Address of the most recent generated store
    logic [31:0] lastTarget;
    int          failCount = 0;

    rvCore uut (
        .clk(clk), .rst(rst),
        .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatRd(iDatRd), .iAck(iAck),
        .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatWr(dDatWr),
        .dSel(dSel), .dDatRd(dDatRd), .dAck(dAck),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRegWrite(retireRegWrite), .retireRd(retireRd), .retireData(retireData)
    );

    tbMemory #(.ADDR_W(IMEM_AW), .SEED(SEED)) imem (
        .clk(clk), .rst(rst), .init(progImage), .cyc(iCyc), .stb(iStb), .we(1'b0),
        .adr(iAdr), .datWr(32'd0), .sel(4'hF), .datRd(iDatRd), .ack(iAck)
    );

    tbMemory #(.ADDR_W(DMEM_AW), .SEED(SEED)) dmem (
        .clk(clk), .rst(rst), .init(dataImage), .cyc(dCyc), .stb(dStb), .we(dWe),
        .adr(dAdr), .datWr(dDatWr), .sel(dSel), .datRd(dDatRd), .ack(dAck)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Destination register, x31 kept as the load and store base
    function automatic logic [4:0] pickRd();
        logic [4:0] v;
        v = 5'(takeBits(5));
        return (v == 5'd31) ? 5'd0 : v;
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return (a * 32'h9E3779B1) ^ 32'h13579BDF;
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // One random instruction, supported or not
    function automatic logic [31:0] genInstr();
        logic [2:0]  cat;
        logic [2:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] tgt;
        logic [31:0] off;
        logic [2:0]  f3;
        logic [31:0] w;
        cat = 3'(takeBits(3));
        sel = 3'(takeBits(3));
        rd  = pickRd();
        rs1 = 5'(takeBits(5));
        rs2 = 5'(takeBits(5));
        imm = 12'(takeBits(12));
        tgt = {24'd0, 6'(takeBits(6)), 2'b00};
        // Half the loads revisit the last store address
        if (cat == 3'd4 && sel[0])
            tgt = lastTarget;
        off = tgt - genBase;
        case (sel)
            3'd1: f3 = 3'b010;
            3'd2: f3 = 3'b100;
            3'd3: f3 = 3'b110;
            3'd4: f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        case (cat)
            // R-type, sel 5 gives SUB
            3'd0: w = {(sel == 3'd5) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
            3'd1, 3'd2: w = encI(imm, rs1, f3, rd, 7'b0010011);
            3'd3: w = {20'(takeBits(20)), rd, 7'b0110111};
            3'd4: w = encI(off[11:0], 5'd31, 3'b010, rd, 7'b0000011);
            3'd5:
            begin
                w = encS(off[11:0], rs2, 5'd31, 3'b010);
                lastTarget = tgt;
            end
            3'd6:
            begin
                // New base, by LUI of zero or by ADDI
                if (sel[0])
                begin
                    w = {20'd0, 5'd31, 7'b0110111};
                    genBase = '0;
                end
                else
                begin
                    genBase = {24'd0, 6'(takeBits(6)), 2'b00};
                    w = encI(genBase[11:0], 5'd0, 3'b000, 5'd31, 7'b0010011);
                end
            end
            default:
            begin
                case (sel)
                    3'd0: w = {imm, rs1, 3'b000, rd, 7'b1100011};
                    3'd1: w = encI(imm, rs1, 3'b001, rd, 7'b0010011);
                    3'd2: w = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
                    3'd3: w = encI(imm, rs1, 3'b000, rd, 7'b0000011);
                    3'd4: w = encS(imm, rs2, rs1, 3'b000);
                    3'd5: w = {imm, rs1, 3'b000, rd, 7'b1101111};
                    3'd6: w = encI(imm, rs1, 3'b011, rd, 7'b0010011);
                    default: w = {imm, rs1, 3'b000, rd, 7'b0010111};
                endcase
            end
        endcase
        return w;
    endfunction

    // Reference execution of one instruction on the model state
    function automatic void refExec(input logic [31:0] ins, output logic wr,
                                    output logic [31:0] data, output logic st,
                                    output logic [31:0] sAddr, output logic [31:0] sData);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rhs;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        logic        isR;
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        immI  = {{20{ins[31]}}, ins[31:20]};
        immS  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        isR   = (ins[6:0] == 7'b0110011);
        rhs   = isR ? b : immI;
        wr    = 1'b0;
        data  = '0;
        st    = 1'b0;
        sAddr = '0;
        sData = '0;
        case (ins[6:0])
            7'b0110111:
            begin
                wr   = 1'b1;
                data = {ins[31:12], 12'd0};
            end
            7'b0010011, 7'b0110011:
            begin
                // R-type accepts func7 zero, or SUB on func3 zero
                if (!isR || ins[31:25] == 7'd0 || (ins[31:25] == 7'b0100000 && ins[14:12] == 3'd0))
                begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000: data = (isR && ins[30]) ? a - rhs : a + rhs;
                        3'b010: data = {31'd0, $signed(a) < $signed(rhs)};
                        3'b100: data = a ^ rhs;
                        3'b110: data = a | rhs;
                        3'b111: data = a & rhs;
                        default: wr = 1'b0;
                    endcase
                end
            end
            7'b0000011:
            begin
                if (ins[14:12] == 3'b010)
                begin
                    addr = a + immI;
                    wr   = 1'b1;
                    data = mmem[addr[DMEM_AW+1:2]];
                end
            end
            7'b0100011:
            begin
                if (ins[14:12] == 3'b010)
                begin
                    addr  = a + immS;
                    mmem[addr[DMEM_AW+1:2]] = b;
                    st    = 1'b1;
                    sAddr = addr;
                    sData = b;
                end
            end
            default:
                wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0)
            mregs[ins[11:7]] = data;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            failCount++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, got);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic waitRetire();
        int cycles;
        cycles = 0;
        while (!retireValid)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
            begin
                $display("Timeout waiting for retireValid after %0d cycles", TIMEOUT);
                $display("*** TEST FAILED ***");
                $fatal(1);
            end
        end
    endtask

    // Every data bus write against the model, once per bus cycle
    always @(negedge clk)
    begin
        if (!rst && dCyc && dWe && !storeSeen)
        begin
            storeSeen = 1'b1;
            assert (storeQ.size() != 0)
            else
            begin
                $display("Data bus write at time %0t with no store expected", $time);
                $display("*** TEST FAILED ***");
                $fatal(1);
            end
            expStore = storeQ.pop_front();
            checkValue("dAdr", dAdr, expStore[63:32]);
            checkValue("dDatWr", dDatWr, expStore[31:0]);
            // Word stores enable every byte lane
            checkValue("dSel", 32'(dSel), 32'hF);
        end
        else if (!dCyc)
            storeSeen = 1'b0;
    end

    initial
    begin
        logic        wr;
        logic        st;
        logic [31:0] data;
        logic [31:0] sa;
        logic [31:0] sd;
        rst        = 1'b1;
        lfsrState  = SEED;
        genBase    = '0;
        lastTarget = '0;

        // Program image, x31 cleared first as the base
        progImage[0] = encI(12'd0, 5'd0, 3'b000, 5'd31, 7'b0010011);
        for (int n = 1; n < 2**IMEM_AW; n++)
            progImage[n] = (n < N_INSTR) ? genInstr() : 32'd0;
        for (int i = 0; i < 2**DMEM_AW; i++)
        begin
            dataImage[i] = fillWord(32'(i * 4));
            mmem[i]      = dataImage[i];
        end
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;

        // Expected retirement sequence
        for (int n = 0; n < N_INSTR; n++)
        begin
            refExec(progImage[n], wr, data, st, sa, sd);
            expWr[n]   = wr;
            expRd[n]   = progImage[n][11:7];
            expData[n] = data;
            if (st)
                storeQ.push_back({sa, sd});
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < N_INSTR; n++)
        begin
            waitRetire();
            checkValue("retirePc", retirePc, 32'(n * 4));
            checkValue("retireRegWrite", 32'(retireRegWrite), 32'(expWr[n]));
            checkValue("retireRd", 32'(retireRd), 32'(expRd[n]));
            if (expWr[n])
                checkValue("retireData", retireData, expData[n]);
            @(negedge clk);
        end

        assert (storeQ.size() == 0)
        else
        begin
            failCount++;
            $display("Expected data bus writes never appeared: %0d left", storeQ.size());
        end

        if (failCount == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

endmodule

// ==== build.f ====
rtl/rvCorePkg.sv
rtl/instrFetch.sv
rtl/decode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/memAccess.sv
rtl/coreSequencer.sv
rtl/rvCore.sv
sim/tbMemory.sv
sim/rvCoreTb.sv

// ==== Makefile ====
# Verilator flow for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
